/* list.f */
coherencePkg.sv
backingRam.sv
memArbiter.sv
directoryUnit.sv
l2TagUnit.sv
opSequencer.sv
coherenceController.sv
tbClock.sv
coherenceControllerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the coherence controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f \
    --top-module coherenceControllerTb -o simv; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/simv 2>&1); then
  echo "$output"
  echo "Simulation exited with a failing status"
  exit 1
fi
echo "$output"

if echo "$output" | grep -q "^NO ERRORS$"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

/* coherenceControllerTb.sv */
`timescale 1ns/1ps

module coherenceControllerTb;

  import coherencePkg::*;

  localparam int resetCycles = 16;
  localparam int scriptedOps = 12;
  localparam int randomOps   = 24;
  localparam int cyclesPerOp = 2000;

  logic        clock;
  logic        reset;
  memOp_t      op;
  logic        opEmpty;
  logic        opTake;
  readReturn_t readReturn;
  logic        returnValid;

  // Reference model of data lines, sharer sets and L2 tags
  logic [wordWidth-1:0]     memData  [2**lineAddrWidth];
  logic [nCores-1:0]        sharers  [2**lineAddrWidth];
  logic                     tagValid [nCores][2**l2IndexWidth];
  logic [lineAddrWidth-1:0] tagLine  [nCores][2**l2IndexWidth];

  readReturn_t expReturn;
  logic        expectRead;
  logic        opPending;
  int          cycleCount;
  logic [15:0] lfsrState;

  tbClock #(.halfPeriod(2), .resetCycles(resetCycles)) u_tbClock (.clock, .reset);

  coherenceController u_coherenceController (
    .clock, .reset, .op, .opEmpty, .opTake, .readReturn, .returnValid
  );

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic reportValue(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    stopWithFailure($sformatf("[ERROR] %s is 0x%0h, expected 0x%0h", name, got, want));
  endtask

  // Fibonacci LFSR with taps 16 14 13 11 and one shift per returned bit
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], feedback};
      value     = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [nCores-1:0] coreBit(input logic [coreIdWidth-1:0] core);
    return nCores'(1) << core;
  endfunction

  // Predicts the response and moves the model to the state after the op
  task automatic applyToModel(input memOp_t o);
    logic [l2IndexWidth-1:0] idx;
    logic                    hit;
    logic [nCores-1:0]       others;
    source_t                 src;
    idx = o.line[l2IndexWidth-1:0];
    hit = tagValid[o.core][idx] && (tagLine[o.core][idx] == o.line);
    if (o.kind == opFlush) begin
      memData[o.line] = o.data;
      sharers[o.line] = sharers[o.line] & ~coreBit(o.core);
      if (hit) tagValid[o.core][idx] = 1'b0;
      expectRead = 1'b0;
    end else begin
      others = sharers[o.line] & ~coreBit(o.core);
      if (hit) begin
        src = srcHit;
      end else if (others != '0) begin
        src = srcPeer;
      end else begin
        src = srcMemory;
      end
      // Conflicting line leaves this core's L2
      if (!hit && tagValid[o.core][idx]) begin
        sharers[tagLine[o.core][idx]] = sharers[tagLine[o.core][idx]] & ~coreBit(o.core);
      end
      if (o.kind == opRead) begin
        sharers[o.line] = sharers[o.line] | coreBit(o.core);
      end else begin
        for (int k = 0; k < nCores; k++) begin
          if (others[k] && tagValid[k][idx] && tagLine[k][idx] == o.line) begin
            tagValid[k][idx] = 1'b0;
          end
        end
        sharers[o.line] = coreBit(o.core);
      end
      tagValid[o.core][idx] = 1'b1;
      tagLine[o.core][idx]  = o.line;
      expReturn  = '{core: o.core, source: src, data: memData[o.line]};
      expectRead = 1'b1;
    end
  endtask

  // One-entry queue that the DUT pops with opTake
  task automatic issueOp(input opKind_t kind, input logic [coreIdWidth-1:0] core,
                         input logic [lineAddrWidth-1:0] line, input logic [31:0] data);
    @(negedge clock);
    op        = '{kind: kind, core: core, line: line, data: data};
    opEmpty   = 1'b0;
    opPending = 1'b1;
    applyToModel(op);
    do @(negedge clock); while (!opTake);
    opEmpty = 1'b1;
    @(negedge clock);
    opPending  = 1'b0;
    expectRead = 1'b0;
  endtask

  always_ff @(posedge clock) begin
    if (reset) begin
      cycleCount <= 0;
    end else begin
      cycleCount <= cycleCount + 1;
    end
  end

  sweepFirst: assert property (@(posedge clock) disable iff (reset)
    (cycleCount < clearCycles) |-> !opTake)
    else stopWithFailure("opTake rose before the RAM clear sweep had finished");

  takeWithReturn: assert property (@(posedge clock) disable iff (reset)
    returnValid |-> opTake)
    else stopWithFailure("returnValid came without opTake in the same cycle");

  returnExpected: assert property (@(posedge clock) disable iff (reset)
    returnValid |-> expectRead)
    else stopWithFailure("returnValid came while no read was outstanding");

  takeExpected: assert property (@(posedge clock) disable iff (reset)
    opTake |-> opPending)
    else stopWithFailure("opTake came while the op queue was empty");

  coreMatches: assert property (@(posedge clock) disable iff (reset)
    returnValid |-> readReturn.core == expReturn.core)
    else reportValue("readReturn.core", 32'($sampled(readReturn.core)),
                     32'($sampled(expReturn.core)));

  sourceMatches: assert property (@(posedge clock) disable iff (reset)
    returnValid |-> readReturn.source == expReturn.source)
    else reportValue("readReturn.source", 32'($sampled(readReturn.source)),
                     32'($sampled(expReturn.source)));

  dataMatches: assert property (@(posedge clock) disable iff (reset)
    returnValid |-> readReturn.data == expReturn.data)
    else reportValue("readReturn.data", $sampled(readReturn.data),
                     $sampled(expReturn.data));

  initial begin
    repeat (resetCycles + clearCycles + (scriptedOps + randomOps) * cyclesPerOp) begin
      @(posedge clock);
    end
    stopWithFailure("Timeout: the DUT stopped taking operations");
  end

  initial begin
    logic [31:0] bits;
    logic [31:0] flushData;
    op         = '0;
    opEmpty    = 1'b1;
    opPending  = 1'b0;
    expectRead = 1'b0;
    expReturn  = '0;
    lfsrState  = 16'd47;
    for (int i = 0; i < 2**lineAddrWidth; i++) begin
      memData[i] = '0;
      sharers[i] = '0;
    end
    for (int c = 0; c < nCores; c++) begin
      for (int i = 0; i < 2**l2IndexWidth; i++) begin
        tagValid[c][i] = 1'b0;
        tagLine[c][i]  = '0;
      end
    end
    wait (!reset);

    // Reads queued while the sweep still runs
    issueOp(opRead, 2'd0, 8'h03, '0);
    issueOp(opRead, 2'd1, 8'h05, '0);

    // Flushed data, then a hit and a peer read of the same line
    flushData = takeBits(32);
    issueOp(opFlush, 2'd2, 8'h20, flushData);
    issueOp(opRead, 2'd3, 8'h20, '0);
    issueOp(opRead, 2'd3, 8'h20, '0);
    issueOp(opRead, 2'd0, 8'h20, '0);

    // Exclusive read by core 2 takes the line from core 1
    issueOp(opRead, 2'd1, 8'h41, '0);
    issueOp(opReadExclusive, 2'd2, 8'h41, '0);
    issueOp(opRead, 2'd1, 8'h41, '0);

    // Same L2 index forces an eviction
    issueOp(opRead, 2'd1, 8'h07, '0);
    issueOp(opRead, 2'd1, 8'h17, '0);
    issueOp(opRead, 2'd3, 8'h07, '0);

    // Random mix over 32 lines so indices collide often
    for (int n = 0; n < randomOps; n++) begin
      opKind_t                  kind;
      logic [coreIdWidth-1:0]   core;
      logic [lineAddrWidth-1:0] line;
      bits = takeBits(2);
      kind = (bits[1:0] == 2'd3) ? opRead : opKind_t'(bits[1:0]);
      bits = takeBits(2);
      core = bits[1:0];
      bits = takeBits(5);
      line = {3'b000, bits[4:0]};
      flushData = (kind == opFlush) ? takeBits(32) : '0;
      issueOp(kind, core, line, flushData);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
  parameter int halfPeriod  = 2,
  parameter int resetCycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(halfPeriod) clock = ~clock;
  end

  // Reset drops on a falling edge as the other stimulus does
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

/* coherenceController.sv */
`timescale 1ns/1ps

module coherenceController (
  input  logic                      clock,
  input  logic                      reset,
  input  coherencePkg::memOp_t      op,
  input  logic                      opEmpty,
  output logic                      opTake,
  output coherencePkg::readReturn_t readReturn,
  output logic                      returnValid
);

  import coherencePkg::*;

  dirCmd_t                  dirCmd;
  logic                     dirStart;
  logic                     dirDone;
  logic                     peerSharers;
  tagCmd_t                  tagCmd;
  logic                     tagStart;
  logic                     tagDone;
  logic                     tagHit;
  logic                     evictValid;
  logic [lineAddrWidth-1:0] evictLine;
  logic                     invReq;
  logic [coreIdWidth-1:0]   invCore;
  logic [lineAddrWidth-1:0] invLine;
  logic                     invDone;

  // RAM port and its three requesters
  ramReq_t                  dirReq;
  ramReq_t                  tagReq;
  ramReq_t                  seqReq;
  logic                     dirGrant;
  logic                     tagGrant;
  logic                     seqGrant;
  logic                     ready;
  logic                     ramWriteEnable;
  logic [ramAddrWidth-1:0]  ramAddress;
  logic [wordWidth-1:0]     ramWriteWord;
  ramWord_u                 ramReadWord;

  opSequencer u_opSequencer (
    .clock, .reset, .ready, .op, .opEmpty, .opTake, .readReturn, .returnValid,
    .dirCmd, .dirStart, .dirDone, .peerSharers,
    .tagCmd, .tagStart, .tagDone, .tagHit, .evictValid, .evictLine,
    .ramReq(seqReq), .ramGrant(seqGrant), .ramReadWord
  );

  directoryUnit u_directoryUnit (
    .clock, .reset, .dirCmd, .dirStart, .dirDone, .peerSharers,
    .ramReq(dirReq), .ramGrant(dirGrant), .ramReadWord,
    .invReq, .invCore, .invLine, .invDone
  );

  l2TagUnit u_l2TagUnit (
    .clock, .reset, .tagCmd, .tagStart, .tagDone, .tagHit, .evictValid, .evictLine,
    .invReq, .invCore, .invLine, .invDone,
    .ramReq(tagReq), .ramGrant(tagGrant), .ramReadWord
  );

  memArbiter u_memArbiter (
    .clock, .reset, .dirReq, .tagReq, .seqReq, .dirGrant, .tagGrant, .seqGrant,
    .ready, .ramWriteEnable, .ramAddress, .ramWriteWord
  );

  backingRam #(
    .addrWidth(ramAddrWidth),
    .wordWidth(wordWidth)
  ) u_backingRam (
    .clock,
    .writeEnable(ramWriteEnable),
    .address(ramAddress),
    .writeWord(ramWriteWord),
    .readWord(ramReadWord)
  );

endmodule

/* opSequencer.sv */
`timescale 1ns/1ps

module opSequencer (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 ready,
  input  coherencePkg::memOp_t                 op,
  input  logic                                 opEmpty,
  output logic                                 opTake,
  output coherencePkg::readReturn_t            readReturn,
  output logic                                 returnValid,
  output coherencePkg::dirCmd_t                dirCmd,
  output logic                                 dirStart,
  input  logic                                 dirDone,
  input  logic                                 peerSharers,
  output coherencePkg::tagCmd_t                tagCmd,
  output logic                                 tagStart,
  input  logic                                 tagDone,
  input  logic                                 tagHit,
  input  logic                                 evictValid,
  input  logic [coherencePkg::lineAddrWidth-1:0] evictLine,
  output coherencePkg::ramReq_t                ramReq,
  input  logic                                 ramGrant,
  input  coherencePkg::ramWord_u               ramReadWord
);

  import coherencePkg::*;

  enum logic [3:0] {
    sIdle, sLookup, sEvict, sDirUpd, sFill, sDataReq, sDataWait,
    sFlushWr, sFlushDir, sFlushClr
  } state;

  memOp_t  cur;
  source_t src;

  always_comb begin
    ramReq          = '0;
    ramReq.valid    = (state == sDataReq) || (state == sFlushWr);
    ramReq.write    = (state == sFlushWr);
    ramReq.address  = {dataRegion, cur.line};
    ramReq.word.raw = cur.data;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= sIdle;
      opTake      <= 1'b0;
      returnValid <= 1'b0;
      dirStart    <= 1'b0;
      tagStart    <= 1'b0;
    end else begin
      opTake      <= 1'b0;
      returnValid <= 1'b0;
      dirStart    <= 1'b0;
      tagStart    <= 1'b0;
      case (state)
        // Skip the cycle of opTake so the popped op is not taken twice
        sIdle: if (ready && !opEmpty && !opTake) begin
          cur <= op;
          if (op.kind == opFlush) begin
            state <= sFlushWr;
          end else begin
            tagCmd   <= '{action: tagLookup, core: op.core, line: op.line};
            tagStart <= 1'b1;
            state    <= sLookup;
          end
        end
        sLookup: if (tagDone) begin
          src <= tagHit ? srcHit : srcMemory;
          if (tagHit && cur.kind == opRead) begin
            state <= sDataReq;
          end else begin
            // Old line leaves the directory before the new one is added
            dirCmd   <= '{kind: (!tagHit && evictValid) ? opFlush : cur.kind,
                          core: cur.core,
                          line: (!tagHit && evictValid) ? evictLine : cur.line};
            dirStart <= 1'b1;
            state    <= (!tagHit && evictValid) ? sEvict : sDirUpd;
          end
        end
        sEvict: if (dirDone) begin
          dirCmd   <= '{kind: cur.kind, core: cur.core, line: cur.line};
          dirStart <= 1'b1;
          state    <= sDirUpd;
        end
        sDirUpd: if (dirDone) begin
          if (src != srcHit && peerSharers) src <= srcPeer;
          tagCmd   <= '{action: tagFill, core: cur.core, line: cur.line};
          tagStart <= 1'b1;
          state    <= sFill;
        end
        sFill: if (tagDone) state <= sDataReq;
        sDataReq: if (ramGrant) state <= sDataWait;
        sDataWait: begin
          readReturn  <= '{core: cur.core, source: src, data: ramReadWord.raw};
          returnValid <= 1'b1;
          opTake      <= 1'b1;
          state       <= sIdle;
        end
        sFlushWr: if (ramGrant) begin
          dirCmd   <= '{kind: opFlush, core: cur.core, line: cur.line};
          dirStart <= 1'b1;
          state    <= sFlushDir;
        end
        sFlushDir: if (dirDone) begin
          tagCmd   <= '{action: tagClear, core: cur.core, line: cur.line};
          tagStart <= 1'b1;
          state    <= sFlushClr;
        end
        default: if (tagDone) begin
          opTake <= 1'b1;
          state  <= sIdle;
        end
      endcase
    end
  end

endmodule

/* l2TagUnit.sv */
`timescale 1ns/1ps

module l2TagUnit (
  input  logic                                 clock,
  input  logic                                 reset,
  input  coherencePkg::tagCmd_t                tagCmd,
  input  logic                                 tagStart,
  output logic                                 tagDone,
  output logic                                 tagHit,
  output logic                                 evictValid,
  output logic [coherencePkg::lineAddrWidth-1:0] evictLine,
  input  logic                                 invReq,
  input  logic [coherencePkg::coreIdWidth-1:0]   invCore,
  input  logic [coherencePkg::lineAddrWidth-1:0] invLine,
  output logic                                 invDone,
  output coherencePkg::ramReq_t                ramReq,
  input  logic                                 ramGrant,
  input  coherencePkg::ramWord_u               ramReadWord
);

  import coherencePkg::*;

  localparam int padWidth = ramAddrWidth - 2 - coreIdWidth - l2IndexWidth;

  enum logic [1:0] {tIdle, tRead, tReadWait, tWrite} state;

  tagCmd_t  cmd;
  logic     fromInv;
  logic     tagMatch;
  ramWord_u writeWord;

  assign tagMatch = ramReadWord.tag.valid && (ramReadWord.tag.tag == cmd.line);

  // A fill stores a valid tag, a clear stores zero
  always_comb begin
    writeWord = '0;
    if (cmd.action == tagFill) begin
      writeWord.tag.valid = 1'b1;
      writeWord.tag.tag   = cmd.line;
    end
  end

  always_comb begin
    ramReq         = '0;
    ramReq.valid   = (state == tRead) || (state == tWrite);
    ramReq.write   = (state == tWrite);
    ramReq.address = {l2Region, padWidth'(0), cmd.core, cmd.line[l2IndexWidth-1:0]};
    ramReq.word    = writeWord;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= tIdle;
      fromInv    <= 1'b0;
      tagDone    <= 1'b0;
      invDone    <= 1'b0;
      tagHit     <= 1'b0;
      evictValid <= 1'b0;
    end else begin
      tagDone <= 1'b0;
      invDone <= 1'b0;
      case (state)
        tIdle: begin
          if (tagStart) begin
            cmd     <= tagCmd;
            fromInv <= 1'b0;
            state   <= (tagCmd.action == tagFill) ? tWrite : tRead;
          end else if (invReq) begin
            cmd     <= '{action: tagClear, core: invCore, line: invLine};
            fromInv <= 1'b1;
            state   <= tRead;
          end
        end
        tRead: if (ramGrant) state <= tReadWait;
        tReadWait: begin
          if (cmd.action == tagLookup) begin
            tagHit     <= tagMatch;
            evictValid <= ramReadWord.tag.valid && !tagMatch;
            evictLine  <= ramReadWord.tag.tag;
            tagDone    <= 1'b1;
            state      <= tIdle;
          end else if (tagMatch) begin
            state <= tWrite;
          end else begin
            // Entry holds another line so nothing is cleared
            tagDone <= !fromInv;
            invDone <= fromInv;
            state   <= tIdle;
          end
        end
        default: if (ramGrant) begin
          tagDone <= !fromInv;
          invDone <= fromInv;
          state   <= tIdle;
        end
      endcase
    end
  end

endmodule

/* directoryUnit.sv */
`timescale 1ns/1ps

module directoryUnit (
  input  logic                                 clock,
  input  logic                                 reset,
  input  coherencePkg::dirCmd_t                dirCmd,
  input  logic                                 dirStart,
  output logic                                 dirDone,
  output logic                                 peerSharers,
  output coherencePkg::ramReq_t                ramReq,
  input  logic                                 ramGrant,
  input  coherencePkg::ramWord_u               ramReadWord,
  output logic                                 invReq,
  output logic [coherencePkg::coreIdWidth-1:0]   invCore,
  output logic [coherencePkg::lineAddrWidth-1:0] invLine,
  input  logic                                 invDone
);

  import coherencePkg::*;

  enum logic [2:0] {dIdle, dRead, dReadWait, dInvScan, dInvWait, dWrite} state;

  dirCmd_t           cmd;
  dirEntry_t         oldEntry;
  logic [nCores-1:0] coreMask;
  logic [nCores-1:0] invMask;
  ramWord_u          newWord;

  assign coreMask = nCores'(1) << cmd.core;
  assign invLine  = cmd.line;

  // Updated entry for the latched command
  always_comb begin
    newWord = '0;
    case (cmd.kind)
      opRead: begin
        newWord.dir.sharers = oldEntry.sharers | coreMask;
        newWord.dir.state   = dirClean;
      end
      opReadExclusive: begin
        newWord.dir.sharers = coreMask;
        newWord.dir.state   = dirModified;
      end
      default: begin
        newWord.dir.sharers = oldEntry.sharers & ~coreMask;
        newWord.dir.state   = dirClean;
      end
    endcase
  end

  always_comb begin
    ramReq         = '0;
    ramReq.valid   = (state == dRead) || (state == dWrite);
    ramReq.write   = (state == dWrite);
    ramReq.address = {dirRegion, cmd.line};
    ramReq.word    = newWord;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= dIdle;
      dirDone     <= 1'b0;
      invReq      <= 1'b0;
      peerSharers <= 1'b0;
    end else begin
      dirDone <= 1'b0;
      invReq  <= 1'b0;
      case (state)
        dIdle: if (dirStart) begin
          cmd   <= dirCmd;
          state <= dRead;
        end
        dRead: if (ramGrant) state <= dReadWait;
        dReadWait: begin
          oldEntry    <= ramReadWord.dir;
          peerSharers <= |(ramReadWord.dir.sharers & ~coreMask);
          invMask     <= ramReadWord.dir.sharers & ~coreMask;
          invCore     <= '0;
          state       <= (cmd.kind == opReadExclusive) ? dInvScan : dWrite;
        end
        // Walk the other sharers one core at a time
        dInvScan: begin
          if (invMask == '0) begin
            state <= dWrite;
          end else if (invMask[invCore]) begin
            invReq           <= 1'b1;
            invMask[invCore] <= 1'b0;
            state            <= dInvWait;
          end else begin
            invCore <= invCore + 1'b1;
          end
        end
        dInvWait: if (invDone) begin
          invCore <= invCore + 1'b1;
          state   <= dInvScan;
        end
        default: if (ramGrant) begin
          dirDone <= 1'b1;
          state   <= dIdle;
        end
      endcase
    end
  end

endmodule

/* memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
  input  logic                                 clock,
  input  logic                                 reset,
  input  coherencePkg::ramReq_t                dirReq,
  input  coherencePkg::ramReq_t                tagReq,
  input  coherencePkg::ramReq_t                seqReq,
  output logic                                 dirGrant,
  output logic                                 tagGrant,
  output logic                                 seqGrant,
  output logic                                 ready,
  output logic                                 ramWriteEnable,
  output logic [coherencePkg::ramAddrWidth-1:0] ramAddress,
  output logic [coherencePkg::wordWidth-1:0]    ramWriteWord
);

  import coherencePkg::*;

  logic [ramAddrWidth-1:0] clearCount;
  ramReq_t                 picked;

  // Sweep writes zero to every address once, then the port opens up
  always_ff @(posedge clock) begin
    if (reset) begin
      clearCount <= '0;
      ready      <= 1'b0;
    end else if (!ready) begin
      clearCount <= clearCount + 1'b1;
      if (clearCount == ramAddrWidth'(clearCycles - 1)) begin
        ready <= 1'b1;
      end
    end
  end

  // Directory has the top priority and the sequencer the lowest
  always_comb begin
    dirGrant = ready && dirReq.valid;
    tagGrant = ready && tagReq.valid && !dirReq.valid;
    seqGrant = ready && seqReq.valid && !dirReq.valid && !tagReq.valid;

    if (dirReq.valid) begin
      picked = dirReq;
    end else if (tagReq.valid) begin
      picked = tagReq;
    end else begin
      picked = seqReq;
    end

    if (!ready) begin
      ramWriteEnable = 1'b1;
      ramAddress     = clearCount;
      ramWriteWord   = '0;
    end else begin
      ramWriteEnable = picked.valid && picked.write;
      ramAddress     = picked.address;
      ramWriteWord   = picked.word.raw;
    end
  end

endmodule

/* backingRam.sv */
`timescale 1ns/1ps

module backingRam #(
  parameter int addrWidth = 10,
  parameter int wordWidth = 32
) (
  input  logic                 clock,
  input  logic                 writeEnable,
  input  logic [addrWidth-1:0] address,
  input  logic [wordWidth-1:0] writeWord,
  output logic [wordWidth-1:0] readWord
);

  // Data lines, directory entries and L2 tags share this array
  logic [wordWidth-1:0] mem [2**addrWidth];

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      mem[address] <= writeWord;
    end
  end

  // Read data shows up one cycle after the address and is the old word on a write
  always_ff @(posedge clock) begin
    readWord <= mem[address];
  end

endmodule

/* coherencePkg.sv */
package coherencePkg;

  localparam int wordWidth     = 32;
  localparam int lineAddrWidth = 8;
  localparam int nCores        = 4;
  localparam int coreIdWidth   = 2;
  localparam int l2IndexWidth  = 4;
  localparam int ramAddrWidth  = 10;
  localparam int clearCycles   = 1024;

  // Upper two RAM address bits select the region
  localparam logic [1:0] dataRegion = 2'b00;
  localparam logic [1:0] dirRegion  = 2'b01;
  localparam logic [1:0] l2Region   = 2'b10;

  // Clean is all zeros so the swept RAM starts clean with no sharers
  typedef enum logic [1:0] {dirClean = 2'b00, dirModified = 2'b10} dirState_t;
  typedef enum logic [1:0] {opRead, opReadExclusive, opFlush} opKind_t;
  typedef enum logic [1:0] {srcHit, srcPeer, srcMemory} source_t;
  typedef enum logic [1:0] {tagLookup, tagFill, tagClear} tagAction_t;

  typedef struct packed {
    opKind_t                  kind;
    logic [coreIdWidth-1:0]   core;
    logic [lineAddrWidth-1:0] line;
    logic [wordWidth-1:0]     data;
  } memOp_t;

  typedef struct packed {
    logic [wordWidth-nCores-3:0] pad;
    logic [nCores-1:0]           sharers;
    dirState_t                   state;
  } dirEntry_t;

  typedef struct packed {
    logic [wordWidth-lineAddrWidth-2:0] pad;
    logic                               valid;
    logic [lineAddrWidth-1:0]           tag;
  } l2Tag_t;

  // One RAM word seen as a directory entry or as an L2 tag
  typedef union packed {
    logic [wordWidth-1:0] raw;
    dirEntry_t            dir;
    l2Tag_t               tag;
  } ramWord_u;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [ramAddrWidth-1:0] address;
    ramWord_u                word;
  } ramReq_t;

  typedef struct packed {
    logic [coreIdWidth-1:0] core;
    source_t                source;
    logic [wordWidth-1:0]   data;
  } readReturn_t;

  // Kind opFlush also covers the eviction of an old L2 line
  typedef struct packed {
    opKind_t                  kind;
    logic [coreIdWidth-1:0]   core;
    logic [lineAddrWidth-1:0] line;
  } dirCmd_t;

  typedef struct packed {
    tagAction_t               action;
    logic [coreIdWidth-1:0]   core;
    logic [lineAddrWidth-1:0] line;
  } tagCmd_t;

endpackage
